// ==== Makefile ====
SRCS := $(wildcard hw/*.sv dv/*.sv)

.PHONY: all run clean

all: obj_dir/VtbTop

# rebuilt only when a source or the file list changes
obj_dir/VtbTop: $(SRCS) sim.f
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module tbTop -f sim.f

run: obj_dir/VtbTop
	@out="$$(./obj_dir/VtbTop)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== dv/tbChecker.sv ====
`timescale 1ns/1ps

module tbChecker (
  input  logic             clk,
  input  logic             arstN,
  input  logic             inValid,
  input  logic             inReady,
  input  logic             outValid,
  input  logic             outReady,
  input  mipsPkg::wordT    outResult,
  input  mipsPkg::regAddrT outDest,
  input  logic             outRegWrite,
  input  logic             outMemRead,
  input  logic             outMemWrite,
  input  mipsPkg::memSizeE outMemSize,
  input  mipsPkg::wordT    outStoreData,
  input  logic             outBranchTaken,
  input  mipsPkg::wordT    outTarget,
  // expected fields held with the instruction
  input  mipsPkg::wordT    expResult,
  input  mipsPkg::regAddrT expDest,
  input  logic             expRegWrite,
  input  logic             expMemRead,
  input  logic             expMemWrite,
  input  mipsPkg::memSizeE expMemSize,
  input  mipsPkg::wordT    expStoreData,
  input  logic             expTaken,
  input  mipsPkg::wordT    expTarget,
  output int               mismatchCount,
  output int               otherCount,
  output int               seenCount
);

  typedef struct packed {
    mipsPkg::wordT    result;
    mipsPkg::regAddrT dest;
    logic             regWrite;
    logic             memRead;
    logic             memWrite;
    mipsPkg::memSizeE size;
    mipsPkg::wordT    storeData;
    logic             taken;
    mipsPkg::wordT    target;
  } expT;

  expT  pending[$];     // accepted and not yet out
  expT  want;
  logic tookIn = 1'b0;  // input transfer on the last edge

  task automatic compare(input string name, input logic [31:0] expVal, input logic [31:0] got);
    if (expVal !== got) begin
      $display("ERR %s expected %h got %h (result %0d)", name, expVal, got, seenCount);
      mismatchCount++;
    end
  endtask

  //////////////////////////////////////////////////
  // both handshakes sampled at the edge
  //////////////////////////////////////////////////
  always @(posedge clk) begin
    if (arstN) begin
      // a result is due one cycle after each accepted instruction
      if (tookIn) compare("outValid", 32'd1, 32'(outValid));
      // input side stalls only while a result waits
      compare("inReady", 32'(!(outValid && !outReady)), 32'(inReady));
      if (outValid && outReady) begin
        seenCount++;
        if (pending.size() == 0) begin
          $display("result %0d left the core with no instruction outstanding", seenCount);
          otherCount++;
        end else begin
          want = pending.pop_front();
          compare("outResult", want.result, outResult);
          compare("outDest", 32'(want.dest), 32'(outDest));
          compare("outRegWrite", 32'(want.regWrite), 32'(outRegWrite));
          compare("outMemRead", 32'(want.memRead), 32'(outMemRead));
          compare("outMemWrite", 32'(want.memWrite), 32'(outMemWrite));
          compare("outMemSize", 32'(want.size), 32'(outMemSize));
          compare("outStoreData", want.storeData, outStoreData);
          compare("outBranchTaken", 32'(want.taken), 32'(outBranchTaken));
          compare("outTarget", want.target, outTarget);
        end
      end
      if (inValid && inReady) begin  // pushed after the pop
        pending.push_back(expT'{expResult, expDest, expRegWrite, expMemRead, expMemWrite,
                                expMemSize, expStoreData, expTaken, expTarget});
      end
      tookIn = inValid && inReady;
    end
  end

endmodule

// ==== dv/tbTop.sv ====
`timescale 1ns/1ps

module tbTop;

  typedef struct packed {
    mipsPkg::wordT    instr;
    mipsPkg::wordT    pc;
    mipsPkg::wordT    result;
    mipsPkg::regAddrT dest;
    logic             regWrite;
    logic             memRead;
    logic             memWrite;
    mipsPkg::memSizeE size;
    mipsPkg::wordT    storeData;
    logic             taken;
    mipsPkg::wordT    target;
  } testT;

  logic             clk = 1'b0;
  logic             arstN = 1'b0;
  logic             inValid = 1'b0;
  logic             inReady;
  mipsPkg::wordT    inInstr = '0;
  mipsPkg::wordT    inPc = '0;
  logic             outValid;
  logic             outReady = 1'b0;
  mipsPkg::wordT    outResult, outStoreData, outTarget;
  mipsPkg::regAddrT outDest;
  logic             outRegWrite, outMemRead, outMemWrite, outBranchTaken;
  mipsPkg::memSizeE outMemSize;
  logic             wbValid = 1'b0;
  mipsPkg::regAddrT wbDest = '0;
  mipsPkg::wordT    wbData = '0;

  mipsPkg::wordT    expResult = '0;
  mipsPkg::regAddrT expDest = '0;
  logic             expRegWrite = 1'b0;
  logic             expMemRead = 1'b0;
  logic             expMemWrite = 1'b0;
  mipsPkg::memSizeE expMemSize = mipsPkg::sizeWord;
  mipsPkg::wordT    expStoreData = '0;
  logic             expTaken = 1'b0;
  mipsPkg::wordT    expTarget = '0;

  int          mismatchCount, otherCount, seenCount;
  int          cycles = 0;
  int          limit = 0;
  int          idx = 0;
  logic [31:0] lcgState = 32'h9367_2b13;
  testT        tests[$];
  testT        cur;

  // r1..r8 before the table runs
  mipsPkg::wordT preloadVals [8] = '{32'h0000_0005, 32'h0000_0003, 32'hffff_fff0,
                                     32'h1234_5678, 32'h0000_1000, 32'h8000_0000,
                                     32'h0000_0005, 32'h0f0f_00ff};

  mipsExecCore dut (
    .clk(clk), .arstN(arstN), .inValid(inValid), .inReady(inReady), .inInstr(inInstr),
    .inPc(inPc), .outValid(outValid), .outReady(outReady), .outResult(outResult),
    .outDest(outDest), .outRegWrite(outRegWrite), .outMemRead(outMemRead),
    .outMemWrite(outMemWrite), .outMemSize(outMemSize), .outStoreData(outStoreData),
    .outBranchTaken(outBranchTaken), .outTarget(outTarget),
    .wbValid(wbValid), .wbDest(wbDest), .wbData(wbData)
  );

  tbChecker chk (
    .clk(clk), .arstN(arstN), .inValid(inValid), .inReady(inReady),
    .outValid(outValid), .outReady(outReady), .outResult(outResult), .outDest(outDest),
    .outRegWrite(outRegWrite), .outMemRead(outMemRead), .outMemWrite(outMemWrite),
    .outMemSize(outMemSize), .outStoreData(outStoreData),
    .outBranchTaken(outBranchTaken), .outTarget(outTarget),
    .expResult(expResult), .expDest(expDest), .expRegWrite(expRegWrite),
    .expMemRead(expMemRead), .expMemWrite(expMemWrite), .expMemSize(expMemSize),
    .expStoreData(expStoreData), .expTaken(expTaken), .expTarget(expTarget),
    .mismatchCount(mismatchCount), .otherCount(otherCount), .seenCount(seenCount)
  );

  //////////////////////////////////////////////////
  // instruction assembly
  //////////////////////////////////////////////////
  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic mipsPkg::wordT encR(input mipsPkg::functT fn, input int rs, rt, rd);
    return {mipsPkg::opRtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
  endfunction

  function automatic mipsPkg::wordT encMul(input int rs, rt, rd);
    return {mipsPkg::opMul, 5'(rs), 5'(rt), 5'(rd), 5'd0, 6'h02};
  endfunction

  function automatic mipsPkg::wordT encI(input mipsPkg::opcodeT op, input int rs, rt,
                                         input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
  endfunction

  function automatic mipsPkg::wordT encJ(input mipsPkg::opcodeT op, input logic [25:0] index);
    return {op, index};
  endfunction

  task automatic addTest(input mipsPkg::wordT instr, pc, result, input mipsPkg::regAddrT dest,
                         input logic rw, mr, mw, input mipsPkg::memSizeE size,
                         input mipsPkg::wordT store, input logic taken,
                         input mipsPkg::wordT target);
    tests.push_back(testT'{instr, pc, result, dest, rw, mr, mw, size, store, taken, target});
  endtask

  task automatic aluTest(input mipsPkg::wordT instr, result, input mipsPkg::regAddrT dest,
                         input mipsPkg::wordT store);
    addTest(instr, 32'h0040_0000 + 32'(tests.size() * 4), result, dest, 1'b1, 1'b0, 1'b0,
            mipsPkg::sizeWord, store, 1'b0, '0);
  endtask

  task automatic memTest(input mipsPkg::wordT instr, addr, input mipsPkg::regAddrT dest,
                         input logic load, input mipsPkg::memSizeE size,
                         input mipsPkg::wordT store);
    addTest(instr, 32'h0040_0000 + 32'(tests.size() * 4), addr, dest, 1'b0, load, !load,
            size, store, 1'b0, '0);
  endtask

  // result and store data both carry the rt register here
  task automatic brTest(input mipsPkg::wordT instr, pc, rtVal, input logic taken,
                        input mipsPkg::wordT target);
    addTest(instr, pc, rtVal, 5'd0, 1'b0, 1'b0, 1'b0, mipsPkg::sizeWord, rtVal, taken, target);
  endtask

  task automatic buildTable();
    aluTest(encR(mipsPkg::fnAdd, 1, 2, 9), 32'h0000_0008, 5'd9, 32'h3);
    aluTest(encR(mipsPkg::fnSub, 1, 2, 10), 32'h0000_0002, 5'd10, 32'h3);
    aluTest(encR(mipsPkg::fnAnd, 4, 8, 11), 32'h0204_0078, 5'd11, 32'h0f0f_00ff);
    aluTest(encR(mipsPkg::fnOr, 4, 8, 12), 32'h1f3f_56ff, 5'd12, 32'h0f0f_00ff);
    aluTest(encR(mipsPkg::fnXor, 4, 8, 13), 32'h1d3b_5687, 5'd13, 32'h0f0f_00ff);
    aluTest(encR(mipsPkg::fnSlt, 3, 1, 14), 32'h0000_0001, 5'd14, 32'h5);
    aluTest(encR(mipsPkg::fnSlt, 1, 3, 15), 32'h0000_0000, 5'd15, 32'hffff_fff0);
    aluTest(encI(mipsPkg::opAddi, 3, 16, 16'hffff), 32'hffff_ffef, 5'd16, '0);
    aluTest(encI(mipsPkg::opAndi, 3, 17, 16'hffff), 32'h0000_fff0, 5'd17, '0);
    aluTest(encI(mipsPkg::opOri, 1, 18, 16'h8000), 32'h0000_8005, 5'd18, '0);
    aluTest(encI(mipsPkg::opXori, 4, 19, 16'hffff), 32'h1234_a987, 5'd19, '0);
    aluTest(encI(mipsPkg::opSlti, 1, 20, 16'hffff), 32'h0000_0000, 5'd20, '0);
    aluTest(encI(mipsPkg::opSlti, 3, 21, 16'h0001), 32'h0000_0001, 5'd21, '0);
    aluTest(encMul(4, 1, 22), 32'h5b05_b058, 5'd22, 32'h5);
    // chain through r24 and r25
    aluTest(encI(mipsPkg::opAddi, 9, 24, 16'h0010), 32'h0000_0018, 5'd24, '0);
    aluTest(encR(mipsPkg::fnAdd, 24, 24, 24), 32'h0000_0030, 5'd24, 32'h18);
    aluTest(encR(mipsPkg::fnSub, 24, 22, 25), 32'ha4fa_4fd8, 5'd25, 32'h5b05_b058);
    memTest(encI(mipsPkg::opLw, 5, 27, 16'h0008), 32'h1008, 5'd27, 1'b1, mipsPkg::sizeWord, '0);
    memTest(encI(mipsPkg::opLh, 5, 28, 16'hfffe), 32'h0ffe, 5'd28, 1'b1, mipsPkg::sizeHalf, '0);
    memTest(encI(mipsPkg::opLb, 5, 29, 16'h0003), 32'h1003, 5'd29, 1'b1, mipsPkg::sizeByte, '0);
    memTest(encI(mipsPkg::opSw, 5, 4, 16'h0004), 32'h1004, 5'd0, 1'b0, mipsPkg::sizeWord,
            32'h1234_5678);
    memTest(encI(mipsPkg::opSh, 5, 8, 16'hfffc), 32'h0ffc, 5'd0, 1'b0, mipsPkg::sizeHalf,
            32'h0f0f_00ff);
    memTest(encI(mipsPkg::opSb, 5, 24, 16'h0010), 32'h1010, 5'd0, 1'b0, mipsPkg::sizeByte,
            32'h30);
    brTest(encI(mipsPkg::opBeq, 1, 7, 16'h0004), 32'h0040_0100, 32'h5, 1'b1, 32'h0040_0114);
    brTest(encI(mipsPkg::opBeq, 1, 2, 16'h0004), 32'h0040_0104, 32'h3, 1'b0, 32'h0040_0118);
    brTest(encI(mipsPkg::opBne, 1, 2, 16'hfffe), 32'h0040_0108, 32'h3, 1'b1, 32'h0040_0104);
    brTest(encI(mipsPkg::opBne, 1, 7, 16'h0001), 32'h0040_010c, 32'h5, 1'b0, 32'h0040_0114);
    brTest(encI(mipsPkg::opBgtz, 1, 0, 16'h0008), 32'h0040_0110, '0, 1'b1, 32'h0040_0134);
    brTest(encI(mipsPkg::opBgtz, 3, 0, 16'h0008), 32'h0040_0114, '0, 1'b0, 32'h0040_0138);
    brTest(encI(mipsPkg::opBlez, 3, 0, 16'h0003), 32'h0040_0118, '0, 1'b1, 32'h0040_0128);
    brTest(encI(mipsPkg::opBlez, 1, 0, 16'h0003), 32'h0040_011c, '0, 1'b0, 32'h0040_012c);
    brTest(encI(mipsPkg::opRegImm, 6, 0, 16'h0010), 32'h0040_0120, '0, 1'b1, 32'h0040_0164);
    brTest(encI(mipsPkg::opRegImm, 1, 0, 16'h0010), 32'h0040_0124, '0, 1'b0, 32'h0040_0168);
    brTest(encI(mipsPkg::opRegImm, 1, 1, 16'hffff), 32'h0040_0128, 32'h5, 1'b1, 32'h0040_0128);
    brTest(encI(mipsPkg::opRegImm, 3, 1, 16'hffff), 32'h0040_012c, 32'h5, 1'b0, 32'h0040_012c);
    brTest(encJ(mipsPkg::opJ, 26'h000_0048), 32'h1000_0130, '0, 1'b1, 32'h1000_0120);
    addTest(encJ(mipsPkg::opJal, 26'h000_0050), 32'h0040_0134, 32'h0040_013c, 5'd31,
            1'b1, 1'b0, 1'b0, mipsPkg::sizeWord, '0, 1'b1, 32'h0000_0140);
    brTest(encR(mipsPkg::fnJr, 31, 0, 0), 32'h0040_0138, '0, 1'b1, 32'h0040_013c);
    // nops, then read back what they must not have touched
    brTest(32'h0000_0000, 32'h0040_0200, '0, 1'b0, '0);
    brTest({6'h3f, 5'd1, 5'd2, 16'h1800}, 32'h0040_0204, 32'h3, 1'b0, '0);
    brTest(encR(6'h3f, 1, 4, 9), 32'h0040_0208, 32'h1234_5678, 1'b0, '0);
    aluTest(encR(mipsPkg::fnOr, 9, 0, 30), 32'h0000_0008, 5'd30, '0);
    aluTest(encR(mipsPkg::fnAdd, 3, 2, 30), 32'hffff_fff3, 5'd30, 32'h3);
  endtask

  //////////////////////////////////////////////////
  // clock, random timing, timeout
  //////////////////////////////////////////////////
  initial begin
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    lcgState <= lcgNext(lcgState);
    outReady <= lcgState[29:28] != 2'b00;  // low about one cycle in four
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout after %0d cycles, %0d of %0d results seen", cycles, seenCount,
               tests.size());
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    buildTable();
    limit = 8 * tests.size() + 100;
    repeat (5) @(posedge clk);
    arstN <= 1'b1;
    for (int r = 1; r <= 8; r++) begin
      @(posedge clk);
      wbValid <= 1'b1;
      wbDest  <= 5'(r);
      wbData  <= preloadVals[r - 1];
    end
    @(posedge clk);
    wbValid <= 1'b0;

    while (idx < tests.size()) begin
      @(posedge clk);
      if (!(inValid && !inReady)) begin  // a pending offer stays put
        if (inValid) idx++;
        if (idx < tests.size() && lcgState[17:16] != 2'b00) begin
          cur = tests[idx];
          inValid      <= 1'b1;
          inInstr      <= cur.instr;
          inPc         <= cur.pc;
          expResult    <= cur.result;
          expDest      <= cur.dest;
          expRegWrite  <= cur.regWrite;
          expMemRead   <= cur.memRead;
          expMemWrite  <= cur.memWrite;
          expMemSize   <= cur.size;
          expStoreData <= cur.storeData;
          expTaken     <= cur.taken;
          expTarget    <= cur.target;
        end else begin
          inValid <= 1'b0;
        end
      end
    end

    while (seenCount < tests.size()) @(negedge clk);
    repeat (4) @(negedge clk);  // catch any extra result
    $display("mismatches %0d, other errors %0d, results %0d of %0d", mismatchCount,
             otherCount, seenCount, tests.size());
    if (mismatchCount == 0 && otherCount == 0 && seenCount == tests.size()) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== hw/controller.sv ====
`timescale 1ns/1ps

module controller (
  input  mipsPkg::wordT    instr,
  output logic             regWrite,
  output logic             memRead,
  output logic             memWrite,
  output logic             useImm,      // operand b from immediate
  output logic             immZeroExt,  // logical immediates
  output logic             link,        // result is return address
  output mipsPkg::regAddrT dest,
  output mipsPkg::memSizeE memSize,
  output mipsPkg::aluOpE   aluOp,
  output mipsPkg::brCondE  brCond
);

  mipsPkg::opcodeT  opcode;
  mipsPkg::functT   funct;
  mipsPkg::regAddrT rt;
  mipsPkg::regAddrT rd;

  assign opcode = instr[31:26];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign funct  = instr[5:0];

  function automatic mipsPkg::memSizeE sizeOf(input mipsPkg::opcodeT op);
    case (op)
      mipsPkg::opLh, mipsPkg::opSh: return mipsPkg::sizeHalf;
      mipsPkg::opLb, mipsPkg::opSb: return mipsPkg::sizeByte;
      default:                      return mipsPkg::sizeWord;
    endcase
  endfunction

  always_comb begin
    // everything inactive unless decoded below
    regWrite   = 1'b0;
    memRead    = 1'b0;
    memWrite   = 1'b0;
    useImm     = 1'b0;
    immZeroExt = 1'b0;
    link       = 1'b0;
    dest       = '0;
    memSize    = mipsPkg::sizeWord;
    aluOp      = mipsPkg::aluPass;
    brCond     = mipsPkg::brNone;

    if (instr != '0) begin  // all-zero word is a nop
      case (opcode)
        mipsPkg::opRtype: begin
          regWrite = 1'b1;
          case (funct)
            mipsPkg::fnAdd: aluOp = mipsPkg::aluAdd;
            mipsPkg::fnSub: aluOp = mipsPkg::aluSub;
            mipsPkg::fnAnd: aluOp = mipsPkg::aluAnd;
            mipsPkg::fnOr:  aluOp = mipsPkg::aluOr;
            mipsPkg::fnXor: aluOp = mipsPkg::aluXor;
            mipsPkg::fnSlt: aluOp = mipsPkg::aluSlt;
            mipsPkg::fnJr: begin
              regWrite = 1'b0;
              brCond   = mipsPkg::brReg;
            end
            default: regWrite = 1'b0;  // unknown funct, nop
          endcase
          if (regWrite) dest = rd;
        end
        mipsPkg::opMul: begin
          regWrite = 1'b1;
          aluOp    = mipsPkg::aluMul;
          dest     = rd;
        end
        mipsPkg::opAddi, mipsPkg::opSlti, mipsPkg::opAndi,
        mipsPkg::opOri, mipsPkg::opXori: begin
          regWrite   = 1'b1;
          useImm     = 1'b1;
          dest       = rt;
          immZeroExt = (opcode != mipsPkg::opAddi) && (opcode != mipsPkg::opSlti);
          case (opcode)
            mipsPkg::opAddi: aluOp = mipsPkg::aluAdd;
            mipsPkg::opSlti: aluOp = mipsPkg::aluSlt;
            mipsPkg::opAndi: aluOp = mipsPkg::aluAnd;
            mipsPkg::opOri:  aluOp = mipsPkg::aluOr;
            default:         aluOp = mipsPkg::aluXor;
          endcase
        end
        mipsPkg::opLw, mipsPkg::opLh, mipsPkg::opLb: begin
          regWrite = 1'b1;  // data itself arrives on write-back
          memRead  = 1'b1;
          useImm   = 1'b1;
          aluOp    = mipsPkg::aluAdd;  // base + offset
          dest     = rt;
          memSize  = sizeOf(opcode);
        end
        mipsPkg::opSw, mipsPkg::opSh, mipsPkg::opSb: begin
          memWrite = 1'b1;
          useImm   = 1'b1;
          aluOp    = mipsPkg::aluAdd;
          memSize  = sizeOf(opcode);
        end
        mipsPkg::opBeq:  brCond = mipsPkg::brEq;
        mipsPkg::opBne:  brCond = mipsPkg::brNe;
        mipsPkg::opBgtz: brCond = mipsPkg::brGtz;
        mipsPkg::opBlez: brCond = mipsPkg::brLez;
        mipsPkg::opRegImm: begin
          if (rt == mipsPkg::rtBltz) brCond = mipsPkg::brLtz;
          else if (rt == mipsPkg::rtBgez) brCond = mipsPkg::brGez;
        end
        mipsPkg::opJ: brCond = mipsPkg::brJump;
        mipsPkg::opJal: begin
          brCond   = mipsPkg::brJump;
          link     = 1'b1;
          regWrite = 1'b1;
          dest     = mipsPkg::linkReg;
        end
        default: ;  // unknown opcode, nop
      endcase
    end
  end

endmodule

// ==== hw/execUnit.sv ====
`timescale 1ns/1ps

module execUnit (
  input  mipsPkg::wordT   instr,
  input  mipsPkg::wordT   pc,
  input  mipsPkg::wordT   rsData,
  input  mipsPkg::wordT   rtData,
  input  mipsPkg::aluOpE  aluOp,
  input  mipsPkg::brCondE brCond,
  input  logic            useImm,
  input  logic            immZeroExt,
  input  logic            link,
  output mipsPkg::wordT   result,
  output logic            branchTaken,
  output mipsPkg::wordT   target
);

  mipsPkg::wordT signImm;
  mipsPkg::wordT immExt;
  mipsPkg::wordT opB;
  mipsPkg::wordT aluRes;
  mipsPkg::wordT pcPlus4;
  logic          rsNeg;
  logic          rsZero;

  assign signImm = {{16{instr[15]}}, instr[15:0]};
  assign immExt  = immZeroExt ? {16'b0, instr[15:0]} : signImm;
  assign opB     = useImm ? immExt : rtData;
  assign pcPlus4 = pc + 32'd4;

  //////////////////////////////////////////////////
  // alu
  //////////////////////////////////////////////////
  always_comb begin
    case (aluOp)
      mipsPkg::aluAdd: aluRes = rsData + opB;
      mipsPkg::aluSub: aluRes = rsData - opB;
      mipsPkg::aluAnd: aluRes = rsData & opB;
      mipsPkg::aluOr:  aluRes = rsData | opB;
      mipsPkg::aluXor: aluRes = rsData ^ opB;
      mipsPkg::aluSlt: aluRes = {31'b0, $signed(rsData) < $signed(opB)};
      mipsPkg::aluMul: aluRes = rsData * opB;  // low word of product
      default:         aluRes = opB;           // aluPass
    endcase
  end

  assign result = link ? pc + 32'd8 : aluRes;  // jal return address

  //////////////////////////////////////////////////
  // branch decision and target
  //////////////////////////////////////////////////
  assign rsNeg  = rsData[31];
  assign rsZero = (rsData == '0);

  always_comb begin
    branchTaken = 1'b0;
    target      = '0;
    case (brCond)
      mipsPkg::brEq:  branchTaken = (rsData == rtData);
      mipsPkg::brNe:  branchTaken = (rsData != rtData);
      mipsPkg::brGtz: branchTaken = !rsNeg && !rsZero;
      mipsPkg::brLez: branchTaken = rsNeg || rsZero;
      mipsPkg::brLtz: branchTaken = rsNeg;
      mipsPkg::brGez: branchTaken = !rsNeg;
      mipsPkg::brJump, mipsPkg::brReg: branchTaken = 1'b1;
      default: ;
    endcase
    if (brCond == mipsPkg::brJump) begin
      target = {pcPlus4[31:28], instr[25:0], 2'b00};  // pseudo-direct
    end else if (brCond == mipsPkg::brReg) begin
      target = rsData;
    end else if (brCond != mipsPkg::brNone) begin
      target = pcPlus4 + {signImm[29:0], 2'b00};
    end
  end

endmodule

// ==== hw/mipsExecCore.sv ====
`timescale 1ns/1ps

module mipsExecCore (
  input  logic             clk,
  input  logic             arstN,
  // instruction in
  input  logic             inValid,
  output logic             inReady,
  input  mipsPkg::wordT    inInstr,
  input  mipsPkg::wordT    inPc,
  // result out
  output logic             outValid,
  input  logic             outReady,
  output mipsPkg::wordT    outResult,
  output mipsPkg::regAddrT outDest,
  output logic             outRegWrite,
  output logic             outMemRead,
  output logic             outMemWrite,
  output mipsPkg::memSizeE outMemSize,
  output mipsPkg::wordT    outStoreData,
  output logic             outBranchTaken,
  output mipsPkg::wordT    outTarget,
  // load data / preload
  input  logic             wbValid,
  input  mipsPkg::regAddrT wbDest,
  input  mipsPkg::wordT    wbData
);

  logic             regWrite, memRead, memWrite;
  logic             useImm, immZeroExt, link;
  mipsPkg::regAddrT dest;
  mipsPkg::memSizeE memSize;
  mipsPkg::aluOpE   aluOp;
  mipsPkg::brCondE  brCond;
  mipsPkg::wordT    rsData, rtData, result, target;
  logic             branchTaken;
  logic             accept;
  logic             execWrite;

  assign inReady   = outReady || !outValid;  // room once output drains
  assign accept    = inValid && inReady;
  assign execWrite = regWrite && !memRead;   // loads write via wb port

  controller ctrl (
    .instr(inInstr), .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
    .useImm(useImm), .immZeroExt(immZeroExt), .link(link), .dest(dest),
    .memSize(memSize), .aluOp(aluOp), .brCond(brCond)
  );

  regFile rf (
    .clk(clk), .arstN(arstN),
    .rdAddrA(inInstr[25:21]), .rdAddrB(inInstr[20:16]),
    .weExec(accept && execWrite), .wdAddrExec(dest), .wdDataExec(result),
    .weWb(wbValid), .wdAddrWb(wbDest), .wdDataWb(wbData),
    .rdDataA(rsData), .rdDataB(rtData)
  );

  execUnit exec (
    .instr(inInstr), .pc(inPc), .rsData(rsData), .rtData(rtData),
    .aluOp(aluOp), .brCond(brCond), .useImm(useImm), .immZeroExt(immZeroExt),
    .link(link), .result(result), .branchTaken(branchTaken), .target(target)
  );

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
    end else if (accept) begin
      outValid <= 1'b1;
    end else if (outReady) begin
      outValid <= 1'b0;  // drained, nothing new
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      outResult      <= result;
      outDest        <= dest;
      outRegWrite    <= execWrite;
      outMemRead     <= memRead;
      outMemWrite    <= memWrite;
      outMemSize     <= memSize;
      outStoreData   <= rtData;
      outBranchTaken <= branchTaken;
      outTarget      <= target;
    end
  end

endmodule

// ==== hw/mipsPkg.sv ====
package mipsPkg;

  //////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////
  typedef logic [31:0] wordT;     // data word
  typedef logic [4:0]  regAddrT;  // register index
  typedef logic [5:0]  opcodeT;   // primary opcode
  typedef logic [5:0]  functT;    // r-type function field

  //////////////////////////////////////////////////
  // control encodings
  //////////////////////////////////////////////////
  typedef enum logic [2:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluMul, aluPass
  } aluOpE;

  typedef enum logic [3:0] {
    brNone, brEq, brNe, brGtz, brLez, brLtz, brGez, brJump, brReg
  } brCondE;

  typedef enum logic [1:0] {
    sizeWord, sizeHalf, sizeByte
  } memSizeE;

  //////////////////////////////////////////////////
  // opcodes
  //////////////////////////////////////////////////
  localparam opcodeT opRtype  = 6'b000000;
  localparam opcodeT opRegImm = 6'b000001;  // bltz / bgez, picked by rt
  localparam opcodeT opJ      = 6'b000010;
  localparam opcodeT opJal    = 6'b000011;
  localparam opcodeT opBeq    = 6'b000100;
  localparam opcodeT opBne    = 6'b000101;
  localparam opcodeT opBlez   = 6'b000110;
  localparam opcodeT opBgtz   = 6'b000111;
  localparam opcodeT opAddi   = 6'b001000;
  localparam opcodeT opSlti   = 6'b001010;
  localparam opcodeT opAndi   = 6'b001100;
  localparam opcodeT opOri    = 6'b001101;
  localparam opcodeT opXori   = 6'b001110;
  localparam opcodeT opMul    = 6'b011100;  // whole opcode means mul
  localparam opcodeT opLb     = 6'b100000;
  localparam opcodeT opLh     = 6'b100001;
  localparam opcodeT opLw     = 6'b100011;
  localparam opcodeT opSb     = 6'b101000;
  localparam opcodeT opSh     = 6'b101001;
  localparam opcodeT opSw     = 6'b101011;

  // r-type funct values
  localparam functT fnJr  = 6'b001000;
  localparam functT fnAdd = 6'b100000;
  localparam functT fnSub = 6'b100010;
  localparam functT fnAnd = 6'b100100;
  localparam functT fnOr  = 6'b100101;
  localparam functT fnXor = 6'b100110;
  localparam functT fnSlt = 6'b101010;

  localparam regAddrT rtBltz  = 5'd0;   // rt field under opRegImm
  localparam regAddrT rtBgez  = 5'd1;
  localparam regAddrT linkReg = 5'd31;  // jal destination

endpackage

// ==== hw/regFile.sv ====
`timescale 1ns/1ps

module regFile (
  input  logic             clk,
  input  logic             arstN,
  input  mipsPkg::regAddrT rdAddrA,
  input  mipsPkg::regAddrT rdAddrB,
  input  logic             weExec,      // write from executed instruction
  input  mipsPkg::regAddrT wdAddrExec,
  input  mipsPkg::wordT    wdDataExec,
  input  logic             weWb,        // load data / preload
  input  mipsPkg::regAddrT wdAddrWb,
  input  mipsPkg::wordT    wdDataWb,
  output mipsPkg::wordT    rdDataA,
  output mipsPkg::wordT    rdDataB
);

  mipsPkg::wordT regs [32];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (weWb && wdAddrWb != '0) begin
        regs[wdAddrWb] <= wdDataWb;
      end
      // exec port overrides write-back on the same index
      if (weExec && wdAddrExec != '0) begin
        regs[wdAddrExec] <= wdDataExec;
      end
    end
  end

  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];  // r0 reads zero
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

// ==== sim.f ====
hw/mipsPkg.sv
hw/controller.sv
hw/regFile.sv
hw/execUnit.sv
hw/mipsExecCore.sv
dv/tbChecker.sv
dv/tbTop.sv
